/* Bender.yml */
package:
  name: vertex_transform_unit

sources:
  - vtu_pkg.sv
  - vtu_matrix_regs.sv
  - vtu_dot_pipe.sv
  - vtu_fix2float.sv
  - vertex_transform_unit.sv
  - target: test
    files:
      - vtu_properties.sv
      - tb_vertex_transform_unit.sv

/* all.f */
vtu_pkg.sv
vtu_matrix_regs.sv
vtu_dot_pipe.sv
vtu_fix2float.sv
vertex_transform_unit.sv
vtu_properties.sv
tb_vertex_transform_unit.sv

/* tb_vertex_transform_unit.sv */
`timescale 1ns/10ps

module tb_vertex_transform_unit import vtu_pkg::*; ();

  localparam int   LATENCY    = 7;
  // Far above the length of all six tests
  localparam int   MAX_CYCLES = 20000;
  localparam fix_t ONE        = 32'h0001_0000;
  localparam fix_t BIG        = 32'h7fff_0000;
  localparam int   VLIM       = 100 << 16;

  logic       aclk, aresetn;
  logic [6:0] awaddr;
  logic       awvalid, awready, wvalid, wready, bvalid, bready;
  fix_t       wdata;
  axil_resp_t bresp;
  vec_t       s_axis_tdata, m_axis_tdata;
  logic       s_axis_tvalid, s_axis_tready, m_axis_tvalid, m_axis_tready;

  int   cyc = 0;
  int   err_resp = 0;
  int   err_vec = 0;
  int   err_other = 0;
  logic bp_on = 1'b0;
  mat_t cur_mat;
  vec_t exp_q[$];
  vec_t out_q[$];
  int   sent_cyc[$];
  int   out_cyc[$];

  vertex_transform_unit #(.FRAC_BITS(FIX_FRAC), .AXIL_ADDR_W(7)) u_dut (.*);

  bind vertex_transform_unit vtu_properties u_props (.*);

  always #4 aclk = ~aclk;

  always @(posedge aclk) begin
    m_axis_tready <= bp_on ? ($urandom % 2 == 1) : 1'b1;
  end

  // Collector and cycle limit
  always @(posedge aclk) begin
    cyc <= cyc + 1;
    if (aresetn && m_axis_tvalid && m_axis_tready) begin
      out_q.push_back(m_axis_tdata);
      out_cyc.push_back(cyc);
    end
    if (cyc == MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test FAILED");
      $finish;
    end
  end

  // Truncating float32 form of one Q16.16 value
  function automatic fp32_t to_fp32(input fix_t f);
    logic [31:0] mag;
    logic [22:0] man;
    int          p;
    if (f == '0) begin
      return '0;
    end
    mag = f[31] ? -f : f;
    p = 31;
    while (!mag[p]) begin
      p--;
    end
    if (p >= 23) begin
      man = 23'(mag >> (p - 23));
    end else begin
      man = 23'(mag << (23 - p));
    end
    return {f[31], 8'(127 + p - FIX_FRAC), man};
  endfunction

  function automatic vec_t model(input mat_t m, input vec_t v);
    logic signed [67:0] sum;
    logic signed [67:0] a;
    logic signed [67:0] b;
    fix_t               r;
    vec_t               res;
    for (int row = 0; row < VEC_N; row++) begin
      sum = '0;
      for (int col = 0; col < VEC_N; col++) begin
        a   = fix_t'(m[(row*VEC_N+col)*32 +: 32]);
        b   = fix_t'(v[col*32 +: 32]);
        sum = sum + a * b;
      end
      sum = sum >>> FIX_FRAC;
      if (sum > FIX_MAX) begin
        r = FIX_MAX;
      end else if (sum < FIX_MIN) begin
        r = FIX_MIN;
      end else begin
        r = fix_t'(sum);
      end
      res[row*32 +: 32] = to_fp32(r);
    end
    return res;
  endfunction

  function automatic vec_t rand_vec(input int lim);
    vec_t v;
    for (int i = 0; i < VEC_N; i++) begin
      v[i*32 +: 32] = fix_t'(int'($urandom_range(2 * lim, 0)) - lim);
    end
    return v;
  endfunction

  task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h actual %h", name, exp, act);
      err_resp++;
    end
  endtask

  task automatic check_vec(input string name, input vec_t exp, input vec_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %h actual %h", name, exp, act);
      err_vec++;
    end
  endtask

  // Lags count cycles before each valid rises
  task automatic axil_write(input logic [6:0] addr, input fix_t data, input int aw_lag,
                            input int w_lag, output axil_resp_t resp);
    int   n;
    logic aw_hs, w_hs, aw_done, w_done;
    n       = 0;
    aw_done = 1'b0;
    w_done  = 1'b0;
    @(posedge aclk);
    while (!(aw_done && w_done)) begin
      if (n == aw_lag) begin
        awaddr  <= addr;
        awvalid <= 1'b1;
      end
      if (n == w_lag) begin
        wdata  <= data;
        wvalid <= 1'b1;
      end
      @(negedge aclk);
      aw_hs = awvalid && awready;
      w_hs  = wvalid && wready;
      @(posedge aclk);
      if (aw_hs) begin
        awvalid <= 1'b0;
        aw_done = 1'b1;
      end
      if (w_hs) begin
        wvalid <= 1'b0;
        w_done = 1'b1;
      end
      n++;
    end
    @(negedge aclk);
    while (!bvalid) begin
      @(negedge aclk);
    end
    resp = bresp;
    // Response waits one cycle before it is taken
    @(posedge aclk);
    bready <= 1'b1;
    @(posedge aclk);
    bready <= 1'b0;
  endtask

  task automatic load_matrix(input mat_t m, input string name);
    axil_resp_t resp;
    for (int i = 0; i < VEC_N * VEC_N; i++) begin
      axil_write(7'(i * 4), m[i*32 +: 32], 0, 0, resp);
      check_resp(name, RESP_OKAY, resp);
    end
    cur_mat = m;
  endtask

  // Starts just after a rising edge and returns just after the accepting one
  task automatic send_vector(input vec_t v);
    s_axis_tdata  <= v;
    s_axis_tvalid <= 1'b1;
    exp_q.push_back(model(cur_mat, v));
    @(negedge aclk);
    while (!s_axis_tready) begin
      @(negedge aclk);
    end
    @(posedge aclk);
    sent_cyc.push_back(cyc);
  endtask

  task automatic drain(input string name, input logic check_lat);
    s_axis_tvalid <= 1'b0;
    while (out_q.size() < exp_q.size()) begin
      @(negedge aclk);
    end
    // Give any stray extra output time to show up
    repeat (LATENCY + 2) @(negedge aclk);
    if (out_q.size() != exp_q.size()) begin
      $display("%s: %0d vectors came out for %0d sent", name, out_q.size(), exp_q.size());
      err_other++;
    end
    foreach (exp_q[i]) begin
      if (i < out_q.size()) begin
        check_vec(name, exp_q[i], out_q[i]);
        if (check_lat && out_cyc[i] - sent_cyc[i] != LATENCY) begin
          $display("ERROR %s: expected latency %0d actual %0d", name, LATENCY,
                   out_cyc[i] - sent_cyc[i]);
          err_other++;
        end
      end
    end
    exp_q.delete();
    out_q.delete();
    sent_cyc.delete();
    out_cyc.delete();
    @(posedge aclk);
  endtask

  task automatic identity_latency();
    mat_t m;
    vec_t v;
    m = '0;
    for (int i = 0; i < VEC_N; i++) begin
      m[(i*VEC_N+i)*32 +: 32] = ONE;
    end
    load_matrix(m, "identity");
    v = rand_vec(VLIM);
    send_vector(v);
    for (int i = 0; i < VEC_N; i++) begin
      exp_q[0][i*32 +: 32] = to_fp32(v[i*32 +: 32]);
    end
    drain("identity", 1'b1);
  endtask

  task automatic general_transform();
    mat_t m;
    for (int i = 0; i < VEC_N * VEC_N; i++) begin
      m[i*32 +: 32] = fix_t'(int'($urandom_range(4 << 16, 0)) - (2 << 16));
    end
    load_matrix(m, "general");
    for (int i = 0; i < 16; i++) begin
      send_vector(rand_vec(VLIM));
    end
    drain("general", 1'b1);
  endtask

  task automatic bad_index_write();
    axil_resp_t resp;
    axil_write(7'(20 * 4), 32'h1234_5678, 0, 0, resp);
    check_resp("bad_write", RESP_SLVERR, resp);
    send_vector(rand_vec(VLIM));
    drain("bad_write", 1'b0);
  endtask

  task automatic stalled_stream();
    bp_on <= 1'b1;
    for (int i = 0; i < 24; i++) begin
      send_vector(rand_vec(VLIM));
    end
    drain("backpressure", 1'b0);
    bp_on <= 1'b0;
  endtask

  task automatic saturation_edges();
    mat_t m;
    m = '0;
    m[0*32 +: 32] = BIG;
    m[4*32 +: 32] = -BIG;
    m[9*32 +: 32] = ONE;
    load_matrix(m, "saturation");
    // Large x and y of 1.5 so rows clamp high and low
    send_vector({32'h0, 32'h0, 32'h0001_8000, BIG});
    send_vector({32'h0, 32'h0, 32'h0001_8000, -BIG});
    send_vector('0);
    exp_q[0] = {32'h0, 32'h3fc0_0000, 32'hc700_0000, 32'h46ff_ffff};
    exp_q[2] = '0;
    drain("saturation", 1'b0);
  endtask

  task automatic write_ordering();
    axil_resp_t resp;
    axil_write(7'(0), 32'h0002_0000, 2, 0, resp);
    check_resp("write_order", RESP_OKAY, resp);
    cur_mat[0*32 +: 32] = 32'h0002_0000;
    axil_write(7'(4 * 4), 32'hffff_8000, 0, 2, resp);
    check_resp("write_order", RESP_OKAY, resp);
    cur_mat[4*32 +: 32] = 32'hffff_8000;
    send_vector(rand_vec(VLIM));
    drain("write_order", 1'b0);
  endtask

  initial begin
    void'($urandom(32'h393b_e455));
    aclk          = 1'b0;
    aresetn       <= 1'b0;
    awaddr        <= '0;
    awvalid       <= 1'b0;
    wdata         <= '0;
    wvalid        <= 1'b0;
    bready        <= 1'b0;
    s_axis_tdata  <= '0;
    s_axis_tvalid <= 1'b0;
    m_axis_tready <= 1'b1;
    cur_mat       = '0;
    repeat (8) @(posedge aclk);
    aresetn <= 1'b1;
    @(posedge aclk);
    identity_latency();
    general_transform();
    bad_index_write();
    stalled_stream();
    saturation_edges();
    write_ordering();
    $display("Errors: resp %0d, vec %0d, other %0d, assert %0d", err_resp, err_vec,
             err_other, u_dut.u_props.fail_cnt);
    if (err_resp + err_vec + err_other + u_dut.u_props.fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* vertex_transform_unit.sv */
`timescale 1ns/10ps

module vertex_transform_unit import vtu_pkg::*; #(
  parameter int FRAC_BITS   = FIX_FRAC,
  parameter int AXIL_ADDR_W = 7
) (
  input  logic                   aclk,
  input  logic                   aresetn,

  // Matrix load, write channels only
  input  logic [AXIL_ADDR_W-1:0] awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  fix_t                   wdata,
  input  logic                   wvalid,
  output logic                   wready,
  output axil_resp_t             bresp,
  output logic                   bvalid,
  input  logic                   bready,

  // Q16.16 vectors in, float32 vectors out
  input  vec_t                   s_axis_tdata,
  input  logic                   s_axis_tvalid,
  output logic                   s_axis_tready,
  output vec_t                   m_axis_tdata,
  output logic                   m_axis_tvalid,
  input  logic                   m_axis_tready
);

  mat_t mat;
  vec_t fix_data;
  logic fix_valid;
  logic fix_ready;

  vtu_matrix_regs #(
    .AXIL_ADDR_W (AXIL_ADDR_W)
  ) u_regs (
    .aclk    (aclk),
    .aresetn (aresetn),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .mat     (mat)
  );

  vtu_dot_pipe #(
    .FRAC_BITS (FRAC_BITS)
  ) u_dot (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .mat       (mat),
    .s_data    (s_axis_tdata),
    .s_valid   (s_axis_tvalid),
    .s_ready   (s_axis_tready),
    .fix_data  (fix_data),
    .fix_valid (fix_valid),
    .fix_ready (fix_ready)
  );

  vtu_fix2float #(
    .FRAC_BITS (FRAC_BITS)
  ) u_f2f (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .fix_data  (fix_data),
    .fix_valid (fix_valid),
    .fix_ready (fix_ready),
    .m_data    (m_axis_tdata),
    .m_valid   (m_axis_tvalid),
    .m_ready   (m_axis_tready)
  );

endmodule

/* vtu_dot_pipe.sv */
`timescale 1ns/10ps

module vtu_dot_pipe import vtu_pkg::*; #(
  parameter int FRAC_BITS = FIX_FRAC
) (
  input  logic aclk,
  input  logic aresetn,

  input  mat_t mat,

  input  vec_t s_data,
  input  logic s_valid,
  output logic s_ready,

  output vec_t fix_data,
  output logic fix_valid,
  input  logic fix_ready
);

  logic  v1, v2, v3, v4;
  logic  rdy1, rdy2, rdy3, rdy4;

  prod_t prod_q [VEC_N*VEC_N];
  acc_t  pair_q [2*VEC_N];
  acc_t  row_q  [VEC_N];
  fix_t  res_q  [VEC_N];

  // Drop the extra fraction bits and clamp into Q16.16
  function automatic fix_t sat_fix(input acc_t acc);
    acc_t sh;
    sh = acc >>> FRAC_BITS;
    if (sh > acc_t'(FIX_MAX)) begin
      return FIX_MAX;
    end
    if (sh < acc_t'(FIX_MIN)) begin
      return FIX_MIN;
    end
    return fix_t'(sh);
  endfunction

  // A stage loads when empty or when the next one takes its item
  assign rdy4    = !v4 || fix_ready;
  assign rdy3    = !v3 || rdy4;
  assign rdy2    = !v2 || rdy3;
  assign rdy1    = !v1 || rdy2;
  assign s_ready = rdy1;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
      v3 <= 1'b0;
      v4 <= 1'b0;
    end else begin
      if (rdy1) v1 <= s_valid;
      if (rdy2) v2 <= v1;
      if (rdy3) v3 <= v2;
      if (rdy4) v4 <= v3;
    end
  end

  always_ff @(posedge aclk) begin
    // Stage 1, sixteen products, column c meets component c
    if (rdy1 && s_valid) begin
      for (int r = 0; r < VEC_N; r++) begin
        for (int c = 0; c < VEC_N; c++) begin
          prod_q[r*VEC_N+c] <= fix_t'(mat[(r*VEC_N+c)*DATA_W +: DATA_W]) *
                               fix_t'(s_data[c*DATA_W +: DATA_W]);
        end
      end
    end

    // Stage 2, pairwise sums per row
    if (rdy2 && v1) begin
      for (int p = 0; p < 2*VEC_N; p++) begin
        pair_q[p] <= acc_t'(prod_q[2*p]) + acc_t'(prod_q[2*p+1]);
      end
    end

    // Stage 3, row sums
    if (rdy3 && v2) begin
      for (int r = 0; r < VEC_N; r++) begin
        row_q[r] <= pair_q[2*r] + pair_q[2*r+1];
      end
    end

    // Stage 4, rescale
    if (rdy4 && v3) begin
      for (int r = 0; r < VEC_N; r++) begin
        res_q[r] <= sat_fix(row_q[r]);
      end
    end
  end

  // Row r becomes component r
  always_comb begin
    for (int r = 0; r < VEC_N; r++) begin
      fix_data[r*DATA_W +: DATA_W] = res_q[r];
    end
  end

  assign fix_valid = v4;

endmodule

/* vtu_fix2float.sv */
`timescale 1ns/10ps

module vtu_fix2float import vtu_pkg::*; #(
  parameter int FRAC_BITS = FIX_FRAC
) (
  input  logic aclk,
  input  logic aresetn,

  input  vec_t fix_data,
  input  logic fix_valid,
  output logic fix_ready,

  output vec_t m_data,
  output logic m_valid,
  input  logic m_ready
);

  // Exponent of a magnitude whose top bit is set
  localparam int EXP_K = FP_BIAS + DATA_W - 1 - FRAC_BITS;

  logic                v1, v2, v3;
  logic                rdy1, rdy2, rdy3;

  logic                sign1 [VEC_N];
  logic [DATA_W-1:0]   mag1  [VEC_N];
  logic [LZ_W-1:0]     lz_c  [VEC_N];
  logic                sign2 [VEC_N];
  logic [DATA_W-1:0]   mag2  [VEC_N];
  logic [LZ_W-1:0]     lz2   [VEC_N];
  logic [FP_EXP_W-1:0] exp2  [VEC_N];
  logic [DATA_W-1:0]   norm_c [VEC_N];
  fp32_t               res_q [VEC_N];

  function automatic logic [DATA_W-1:0] abs_mag(input fix_t v);
    return v[DATA_W-1] ? -v : v;
  endfunction

  // Zero input counts as DATA_W leading zeros
  function automatic logic [LZ_W-1:0] lzc(input logic [DATA_W-1:0] val);
    logic [LZ_W-1:0] cnt;
    logic            found;
    cnt   = LZ_W'(DATA_W);
    found = 1'b0;
    for (int i = DATA_W - 1; i >= 0; i--) begin
      if (!found && val[i]) begin
        cnt   = LZ_W'(DATA_W - 1 - i);
        found = 1'b1;
      end
    end
    return cnt;
  endfunction

  assign rdy3      = !v3 || m_ready;
  assign rdy2      = !v2 || rdy3;
  assign rdy1      = !v1 || rdy2;
  assign fix_ready = rdy1;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
      v3 <= 1'b0;
    end else begin
      if (rdy1) v1 <= fix_valid;
      if (rdy2) v2 <= v1;
      if (rdy3) v3 <= v2;
    end
  end

  always_comb begin
    for (int i = 0; i < VEC_N; i++) begin
      lz_c[i]   = lzc(mag1[i]);
      norm_c[i] = mag2[i] << lz2[i];
    end
  end

  always_ff @(posedge aclk) begin
    // Stage 1, sign and magnitude
    if (rdy1 && fix_valid) begin
      for (int i = 0; i < VEC_N; i++) begin
        sign1[i] <= fix_data[i*DATA_W + DATA_W - 1];
        mag1[i]  <= abs_mag(fix_data[i*DATA_W +: DATA_W]);
      end
    end

    // Stage 2, leading zeros and biased exponent
    if (rdy2 && v1) begin
      for (int i = 0; i < VEC_N; i++) begin
        sign2[i] <= sign1[i];
        mag2[i]  <= mag1[i];
        lz2[i]   <= lz_c[i];
        exp2[i]  <= (mag1[i] == '0) ? '0 : FP_EXP_W'(EXP_K - int'(lz_c[i]));
      end
    end

    // Stage 3, normalize, truncate mantissa and pack
    if (rdy3 && v2) begin
      for (int i = 0; i < VEC_N; i++) begin
        if (mag2[i] == '0) begin
          res_q[i] <= '0;
        end else begin
          res_q[i] <= {sign2[i], exp2[i], norm_c[i][DATA_W-2 -: FP_MANT_W]};
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < VEC_N; i++) begin
      m_data[i*DATA_W +: DATA_W] = res_q[i];
    end
  end

  assign m_valid = v3;

endmodule

/* vtu_matrix_regs.sv */
`timescale 1ns/10ps

module vtu_matrix_regs import vtu_pkg::*; #(
  parameter int AXIL_ADDR_W = 7
) (
  input  logic                   aclk,
  input  logic                   aresetn,

  input  logic [AXIL_ADDR_W-1:0] awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  fix_t                   wdata,
  input  logic                   wvalid,
  output logic                   wready,
  output axil_resp_t             bresp,
  output logic                   bvalid,
  input  logic                   bready,

  output mat_t                   mat
);

  // Byte address, word aligned
  localparam int ADDR_LSB  = 2;
  localparam int IDX_W     = AXIL_ADDR_W - ADDR_LSB;
  localparam int MAT_WORDS = VEC_N * VEC_N;
  localparam int MAT_IDX_W = $clog2(MAT_WORDS);

  wr_state_t        state;
  logic             aw_held;
  logic             w_held;
  logic [IDX_W-1:0] aw_idx;
  fix_t             wdata_q;
  axil_resp_t       bresp_q;
  fix_t             mat_q [MAT_WORDS];

  // Ask only for the beat still missing
  assign awready = (state == WR_ACCEPT) && !aw_held;
  assign wready  = (state == WR_ACCEPT) && !w_held;
  assign bvalid  = (state == WR_RESP);
  assign bresp   = bresp_q;

  always_ff @(posedge aclk) begin
    if (awvalid && awready) begin
      aw_idx <= awaddr[AXIL_ADDR_W-1:ADDR_LSB];
    end
    if (wvalid && wready) begin
      wdata_q <= wdata;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state   <= WR_ACCEPT;
      aw_held <= 1'b0;
      w_held  <= 1'b0;
      bresp_q <= RESP_OKAY;
      for (int i = 0; i < MAT_WORDS; i++) begin
        mat_q[i] <= '0;
      end
    end else begin
      case (state)
        WR_ACCEPT: begin
          if (awvalid && awready) begin
            aw_held <= 1'b1;
          end
          if (wvalid && wready) begin
            w_held <= 1'b1;
          end
          // Both halves in hand, commit or reject
          if (aw_held && w_held) begin
            if (aw_idx < MAT_WORDS) begin
              mat_q[aw_idx[MAT_IDX_W-1:0]] <= wdata_q;
              bresp_q <= RESP_OKAY;
            end else begin
              bresp_q <= RESP_SLVERR;
            end
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            state   <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (bready) begin
            state <= WR_ACCEPT;
          end
        end
        default: state <= WR_ACCEPT;
      endcase
    end
  end

  always_comb begin
    for (int i = 0; i < MAT_WORDS; i++) begin
      mat[i*DATA_W +: DATA_W] = mat_q[i];
    end
  end

endmodule

/* vtu_pkg.sv */
package vtu_pkg;

  // Fixed-point data path
  localparam int DATA_W   = 32;
  localparam int VEC_N    = 4;
  localparam int FIX_FRAC = 16;

  typedef logic signed [DATA_W-1:0]     fix_t;
  typedef logic        [31:0]           fp32_t;
  typedef logic signed [2*DATA_W-1:0]   prod_t;
  // Two guard bits for the sum of four products
  typedef logic signed [2*DATA_W+1:0]   acc_t;

  // Component 0 (x) in the lowest word
  typedef logic [VEC_N*DATA_W-1:0]       vec_t;
  // Coefficient (r, c) at word r*VEC_N + c
  typedef logic [VEC_N*VEC_N*DATA_W-1:0] mat_t;

  // Saturation limits of one Q16.16 word
  localparam fix_t FIX_MAX = {1'b0, {(DATA_W-1){1'b1}}};
  localparam fix_t FIX_MIN = {1'b1, {(DATA_W-1){1'b0}}};

  // float32 fields
  localparam int FP_EXP_W  = 8;
  localparam int FP_MANT_W = 23;
  localparam int FP_BIAS   = 127;
  // Leading-zero count covers 0 .. DATA_W
  localparam int LZ_W      = $clog2(DATA_W) + 1;

  // AXI write response codes
  typedef logic [1:0] axil_resp_t;
  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  typedef enum logic {
    WR_ACCEPT,
    WR_RESP
  } wr_state_t;

endpackage

/* vtu_properties.sv */
`timescale 1ns/10ps

module vtu_properties import vtu_pkg::*; (
  input logic       aclk,
  input logic       aresetn,
  input vec_t       m_axis_tdata,
  input logic       m_axis_tvalid,
  input logic       m_axis_tready,
  input axil_resp_t bresp,
  input logic       bvalid,
  input logic       bready
);

  // Number of assertion failures so far
  int fail_cnt = 0;

  // Stalled output keeps its item
  a_out_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata))
    else begin
      $error("m_axis output changed while stalled");
      fail_cnt++;
    end

  // Write response held until taken
  a_resp_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      $error("bvalid or bresp changed before bready");
      fail_cnt++;
    end

  a_reset_idle: assert property (@(posedge aclk) !aresetn |=> !m_axis_tvalid)
    else begin
      $error("m_axis_tvalid high in the cycle after reset");
      fail_cnt++;
    end

endmodule
